/* filelist.f */
+incdir+.
core_types_pkg.sv
rs_pkg.sv
rs_entry.sv
dispatch_selector.sv
issue_selector.sv
reservation_station.sv
rs_issue_top.sv
tb_rs_issue.sv

/* tb_rs_issue.sv */
// testbench for the issue stage, run as top over the file list, checks issue behavior with assertions
`timescale 1ns/1ps
`include "rs_defines.svh"

module tb_rs_issue;

    logic                                       clock;
    logic                                       reset;
    logic                                       flush_i;
    logic                 [`DISPATCH_WIDTH-1:0] disp_valid_i;
    rs_pkg::disp_packet_t [`DISPATCH_WIDTH-1:0] disp_packets_i;
    core_types_pkg::cdb_t [`CDB_WIDTH-1:0]      cdb_i;
    logic                 [`FU_NUM-1:0]         fu_busy_i;
    logic                                       br_resolve_i;
    logic                                       br_mispredict_i;
    logic [$clog2(`DISPATCH_WIDTH+1)-1:0]       free_slots_o;
    logic                                       rs_full_o;
    rs_pkg::issue_packet_t [`FU_NUM-1:0]        issue_o;

    // expected set, one slot per rob index
    rs_pkg::disp_packet_t  exp_pkt [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] live;
    logic [`ROB_DEPTH-1:0] spec;
    logic [`ROB_DEPTH-1:0] wait1;
    logic [`ROB_DEPTH-1:0] wait2;
    logic [`ROB_DEPTH-1:0] done;
    logic                  br_pending;
    int                    next_rob;
    // derived view of the set
    logic [`FU_NUM-1:0]    exp_ready;
    int                    live_count;
    int                    exp_free;

    rs_issue_top dut (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush_i),
        .disp_valid_i    (disp_valid_i),
        .disp_packets_i  (disp_packets_i),
        .cdb_i           (cdb_i),
        .fu_busy_i       (fu_busy_i),
        .br_resolve_i    (br_resolve_i),
        .br_mispredict_i (br_mispredict_i),
        .free_slots_o    (free_slots_o),
        .rs_full_o       (rs_full_o),
        .issue_o         (issue_o)
    );

    always #10 clock = ~clock;

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    // any bus lane carrying this tag
    function automatic logic bus_hit(input core_types_pkg::phys_tag_t t);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < `CDB_WIDTH; l++) begin
            hit = hit || (cdb_i[l].valid && (cdb_i[l].tag == t));
        end
        return hit;
    endfunction

    // ==============================
    // expected-set model
    // ==============================
    always @(posedge clock) begin : expect_model
        logic                     pend;
        core_types_pkg::rob_idx_t r;
        if (reset) begin
            live       = '0;
            spec       = '0;
            done       = '0;
            br_pending = 1'b0;
        end else begin
            // wakeup of stored sources
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (live[i] && bus_hit(exp_pkt[i].src1_tag)) wait1[i] = 1'b0;
                if (live[i] && bus_hit(exp_pkt[i].src2_tag)) wait2[i] = 1'b0;
            end
            for (int f = 0; f < `FU_NUM; f++) begin
                if (issue_o[f].valid) begin
                    live[issue_o[f].rob_idx] = 1'b0;
                    done[issue_o[f].rob_idx] = 1'b1;
                end
            end
            // wrong path is dropped, any resolution ends the window
            if (br_mispredict_i) live = live & ~spec;
            if (br_resolve_i || br_mispredict_i) spec = '0;
            pend = br_pending && !(br_resolve_i || br_mispredict_i);
            for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
                if (disp_valid_i[s] && !br_mispredict_i) begin
                    r          = disp_packets_i[s].rob_idx;
                    exp_pkt[r] = disp_packets_i[s];
                    live[r]    = 1'b1;
                    done[r]    = 1'b0;
                    spec[r]    = pend;
                    wait1[r]   = !disp_packets_i[s].src1_ready
                                 && !bus_hit(disp_packets_i[s].src1_tag);
                    wait2[r]   = !disp_packets_i[s].src2_ready
                                 && !bus_hit(disp_packets_i[s].src2_tag);
                    // later slots sit behind it
                    if (disp_packets_i[s].fu_type == core_types_pkg::FU_BRANCH) pend = 1'b1;
                end
            end
            if (flush_i) begin
                live = '0;
                spec = '0;
                pend = 1'b0;
            end
            br_pending = pend;
        end
    end

    always_comb begin
        exp_ready  = '0;
        live_count = 0;
        for (int r = 0; r < `ROB_DEPTH; r++) begin
            live_count += live[r];
            if (live[r] && !wait1[r] && !wait2[r]) exp_ready[exp_pkt[r].fu_type] = 1'b1;
        end
        exp_free = (`RS_DEPTH - live_count < `DISPATCH_WIDTH) ?
                   `RS_DEPTH - live_count : `DISPATCH_WIDTH;
    end

    // ==============================
    // checks
    // ==============================
    for (genvar f = 0; f < `FU_NUM; f++) begin : g_port
        core_types_pkg::fu_type_e owner;
        logic [$bits(core_types_pkg::op_code_t)+3*$bits(core_types_pkg::phys_tag_t)-1:0] got;
        logic [$bits(core_types_pkg::op_code_t)+3*$bits(core_types_pkg::phys_tag_t)-1:0] want;
        assign owner = exp_pkt[issue_o[f].rob_idx].fu_type;
        assign got   = {issue_o[f].op, issue_o[f].dest_tag, issue_o[f].src1_tag,
                        issue_o[f].src2_tag};
        assign want  = {exp_pkt[issue_o[f].rob_idx].op, exp_pkt[issue_o[f].rob_idx].dest_tag,
                        exp_pkt[issue_o[f].rob_idx].src1_tag, exp_pkt[issue_o[f].rob_idx].src2_tag};

        // a second issue of one rob also lands here
        a_known: assert property (@(posedge clock) disable iff (reset)
            issue_o[f].valid |-> live[issue_o[f].rob_idx])
            else report_fail($sformatf("rob %0d issued on port %0d while not in flight",
                $sampled(issue_o[f].rob_idx), f));
        a_type: assert property (@(posedge clock) disable iff (reset)
            issue_o[f].valid |-> (owner == core_types_pkg::fu_type_e'(f)))
            else report_fail($sformatf("ERROR: issue_o[%0d] unit 0x%h expected 0x%h",
                f, f, $sampled(owner)));
        a_payload: assert property (@(posedge clock) disable iff (reset)
            issue_o[f].valid |-> (got == want))
            else report_fail($sformatf("ERROR: issue_o[%0d] op and tags 0x%h expected 0x%h",
                f, $sampled(got), $sampled(want)));
        a_woken: assert property (@(posedge clock) disable iff (reset)
            issue_o[f].valid |-> (!wait1[issue_o[f].rob_idx] && !wait2[issue_o[f].rob_idx]))
            else report_fail($sformatf("rob %0d issued before its source tags were broadcast",
                $sampled(issue_o[f].rob_idx)));
        a_not_busy: assert property (@(posedge clock) disable iff (reset)
            issue_o[f].valid |-> !fu_busy_i[f])
            else report_fail($sformatf("port %0d issued while its unit was busy", f));
        // ready work for a free unit goes out this cycle
        a_due: assert property (@(posedge clock) disable iff (reset)
            (exp_ready[f] && !fu_busy_i[f]) |-> issue_o[f].valid)
            else report_fail($sformatf("ERROR: issue_o[%0d].valid 0x0 expected 0x1", f));
    end

    a_free: assert property (@(posedge clock) disable iff (reset) free_slots_o == exp_free)
        else report_fail($sformatf("ERROR: free_slots_o 0x%h expected 0x%h",
            $sampled(free_slots_o), $sampled(exp_free)));
    a_full: assert property (@(posedge clock) disable iff (reset)
        rs_full_o == (live_count == `RS_DEPTH))
        else report_fail($sformatf("ERROR: rs_full_o 0x%h expected 0x%h",
            $sampled(rs_full_o), $sampled(live_count == `RS_DEPTH)));

    // ==============================
    // stimulus
    // ==============================
    function automatic rs_pkg::disp_packet_t make_pkt(input core_types_pkg::fu_type_e fu,
        input core_types_pkg::phys_tag_t t1, input logic r1,
        input core_types_pkg::phys_tag_t t2, input logic r2);
        rs_pkg::disp_packet_t p;
        // skip rob indices still in flight
        while (live[next_rob]) next_rob = (next_rob + 1) % `ROB_DEPTH;
        p.fu_type    = fu;
        p.op         = core_types_pkg::op_code_t'($urandom);
        p.dest_tag   = core_types_pkg::phys_tag_t'($urandom);
        p.src1_tag   = t1;
        p.src1_ready = r1;
        p.src2_tag   = t2;
        p.src2_ready = r2;
        p.rob_idx    = core_types_pkg::rob_idx_t'(next_rob);
        next_rob     = (next_rob + 1) % `ROB_DEPTH;
        return p;
    endfunction

    // one active cycle, then quiet inputs, returns at the falling edge
    task automatic drive_cycle(input logic [`DISPATCH_WIDTH-1:0] v,
        input rs_pkg::disp_packet_t p0, input rs_pkg::disp_packet_t p1,
        input core_types_pkg::cdb_t bus, input logic res, input logic mis, input logic fl);
        int lane;
        // result rides on any one of the bus lanes
        lane = $urandom_range(`CDB_WIDTH - 1, 0);
        @(posedge clock);
        disp_valid_i      <= v;
        disp_packets_i[0] <= p0;
        disp_packets_i[1] <= p1;
        cdb_i[lane]       <= bus;
        br_resolve_i      <= res;
        br_mispredict_i   <= mis;
        flush_i           <= fl;
        @(posedge clock);
        disp_valid_i      <= '0;
        cdb_i             <= '0;
        br_resolve_i      <= 1'b0;
        br_mispredict_i   <= 1'b0;
        flush_i           <= 1'b0;
        @(negedge clock);
    endtask

    task automatic dispatch(input logic [`DISPATCH_WIDTH-1:0] v,
        input rs_pkg::disp_packet_t p0, input rs_pkg::disp_packet_t p1);
        drive_cycle(v, p0, p1, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic broadcast(input core_types_pkg::phys_tag_t t);
        drive_cycle('0, '0, '0, '{valid: 1'b1, tag: t}, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic set_busy(input logic [`FU_NUM-1:0] b);
        @(posedge clock);
        fu_busy_i <= b;
        @(negedge clock);
    endtask

    task automatic wait_issued(input core_types_pkg::rob_idx_t r, input int limit);
        int n;
        n = 0;
        while (!done[r] && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (!done[r]) report_fail($sformatf("timed out waiting for rob %0d to issue", r));
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (live_count != 0 && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (live_count != 0) report_fail("timed out waiting for the station to drain");
    endtask

    initial begin
        rs_pkg::disp_packet_t      p0;
        rs_pkg::disp_packet_t      p1;
        rs_pkg::disp_packet_t      p2;
        core_types_pkg::phys_tag_t tag_a;
        core_types_pkg::phys_tag_t pool [4];
        void'($urandom(32'hdfca7a78));
        clock           = 1'b0;
        reset           = 1'b1;
        flush_i         = 1'b0;
        disp_valid_i    = '0;
        disp_packets_i  = '0;
        cdb_i           = '0;
        fu_busy_i       = '0;
        br_resolve_i    = 1'b0;
        br_mispredict_i = 1'b0;
        next_rob        = 0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        // idle station right after reset
        repeat (3) @(negedge clock);

        // ready instructions, one per unit type, then two of one type
        for (int f = 0; f < `FU_NUM; f++) begin
            p0 = make_pkt(core_types_pkg::fu_type_e'(f), 6'd1, 1'b1, 6'd2, 1'b1);
            dispatch(2'b01, p0, p0);
            wait_issued(p0.rob_idx, 10);
        end
        p0 = make_pkt(core_types_pkg::FU_MULT, 6'd3, 1'b1, 6'd4, 1'b1);
        p1 = make_pkt(core_types_pkg::FU_MULT, 6'd5, 1'b1, 6'd6, 1'b1);
        dispatch(2'b11, p0, p1);
        wait_issued(p0.rob_idx, 10);
        wait_issued(p1.rob_idx, 10);

        // wakeup, a later bus cycle and the dispatch cycle itself
        tag_a = core_types_pkg::phys_tag_t'($urandom);
        p0 = make_pkt(core_types_pkg::FU_ALU, tag_a, 1'b0, 6'd7, 1'b1);
        dispatch(2'b01, p0, p0);
        repeat (3) @(negedge clock);
        broadcast(tag_a);
        wait_issued(p0.rob_idx, 10);
        p0 = make_pkt(core_types_pkg::FU_LOAD, 6'd8, 1'b1, tag_a + 6'd1, 1'b0);
        drive_cycle(2'b01, p0, p0, '{valid: 1'b1, tag: tag_a + 6'd1}, 1'b0, 1'b0, 1'b0);
        wait_issued(p0.rob_idx, 10);

        // ==============================
        // back-pressure
        // ==============================
        set_busy('1);
        for (int k = 0; k < `RS_DEPTH / `DISPATCH_WIDTH; k++) begin
            p0 = make_pkt(core_types_pkg::fu_type_e'($urandom_range(3, 0)), 6'd9, 1'b1, 6'd10, 1'b1);
            p1 = make_pkt(core_types_pkg::fu_type_e'($urandom_range(3, 0)), 6'd11, 1'b1, 6'd12, 1'b1);
            dispatch(2'b11, p0, p1);
        end
        repeat (4) @(negedge clock);
        set_busy('0);
        wait_drain(40);

        // ==============================
        // branch resolution
        // ==============================
        // close any window left open above
        drive_cycle('0, '0, '0, '0, 1'b1, 1'b0, 1'b0);
        tag_a = core_types_pkg::phys_tag_t'($urandom);
        p0 = make_pkt(core_types_pkg::FU_ALU, tag_a, 1'b0, 6'd13, 1'b1);
        dispatch(2'b01, p0, p0);
        // younger in the same group as the branch
        p1 = make_pkt(core_types_pkg::FU_BRANCH, 6'd14, 1'b1, 6'd15, 1'b1);
        p2 = make_pkt(core_types_pkg::FU_ALU, tag_a, 1'b0, 6'd16, 1'b1);
        dispatch(2'b11, p1, p2);
        drive_cycle('0, '0, '0, '0, 1'b0, 1'b1, 1'b0);
        broadcast(tag_a);
        wait_issued(p0.rob_idx, 10);
        repeat (4) @(negedge clock);
        if (done[p2.rob_idx]) report_fail("instruction squashed by a mispredict was issued");
        // correct resolve keeps the younger one alive through a later mispredict
        p1 = make_pkt(core_types_pkg::FU_BRANCH, 6'd17, 1'b1, 6'd18, 1'b1);
        dispatch(2'b01, p1, p1);
        p2 = make_pkt(core_types_pkg::FU_MULT, 6'd19, 1'b1, tag_a + 6'd2, 1'b0);
        dispatch(2'b01, p2, p2);
        drive_cycle('0, '0, '0, '0, 1'b1, 1'b0, 1'b0);
        p1 = make_pkt(core_types_pkg::FU_BRANCH, 6'd20, 1'b1, 6'd21, 1'b1);
        dispatch(2'b01, p1, p1);
        drive_cycle('0, '0, '0, '0, 1'b0, 1'b1, 1'b0);
        broadcast(tag_a + 6'd2);
        wait_issued(p2.rob_idx, 10);

        // ==============================
        // flush
        // ==============================
        set_busy('1);
        p0 = make_pkt(core_types_pkg::FU_ALU, 6'd22, 1'b1, 6'd23, 1'b1);
        p1 = make_pkt(core_types_pkg::FU_LOAD, 6'd24, 1'b1, 6'd25, 1'b1);
        dispatch(2'b11, p0, p1);
        drive_cycle('0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
        set_busy('0);
        repeat (4) @(negedge clock);
        wait_drain(10);

        // random mix over a small tag pool
        foreach (pool[i]) pool[i] = core_types_pkg::phys_tag_t'($urandom);
        for (int it = 0; it < 40; it++) begin
            case ($urandom_range(2, 0))
                0: begin
                    if (live_count <= `RS_DEPTH - `DISPATCH_WIDTH) begin
                        p0 = make_pkt(core_types_pkg::fu_type_e'($urandom_range(3, 0)),
                                      pool[$urandom_range(3, 0)], 1'($urandom_range(1, 0)),
                                      pool[$urandom_range(3, 0)], 1'($urandom_range(1, 0)));
                        p1 = make_pkt(core_types_pkg::fu_type_e'($urandom_range(3, 0)),
                                      pool[$urandom_range(3, 0)], 1'($urandom_range(1, 0)),
                                      pool[$urandom_range(3, 0)], 1'($urandom_range(1, 0)));
                        dispatch(2'($urandom_range(3, 1)), p0, p1);
                    end
                end
                1: broadcast(pool[$urandom_range(3, 0)]);
                default: set_busy(4'($urandom));
            endcase
        end
        set_busy('0);
        foreach (pool[i]) broadcast(pool[i]);
        wait_drain(60);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* rs_issue_top.sv */
// issue stage top, reservation station feeding the per-unit issue pick
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_issue_top (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        flush_i,
    input  logic                 [`DISPATCH_WIDTH-1:0]  disp_valid_i,
    input  rs_pkg::disp_packet_t [`DISPATCH_WIDTH-1:0]  disp_packets_i,
    input  core_types_pkg::cdb_t [`CDB_WIDTH-1:0]       cdb_i,
    input  logic                 [`FU_NUM-1:0]          fu_busy_i,
    input  logic                                        br_resolve_i,
    input  logic                                        br_mispredict_i,
    output logic [$clog2(`DISPATCH_WIDTH+1)-1:0]        free_slots_o,
    output logic                                        rs_full_o,
    output rs_pkg::issue_packet_t [`FU_NUM-1:0]         issue_o
);

    // station to selector
    rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries;
    logic              [`RS_DEPTH-1:0] ready;
    // selector back to station
    logic              [`RS_DEPTH-1:0] issue_enable;

    reservation_station u_rs (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush_i),
        .disp_valid_i    (disp_valid_i),
        .disp_packets_i  (disp_packets_i),
        .cdb_i           (cdb_i),
        .issue_enable_i  (issue_enable),
        .br_resolve_i    (br_resolve_i),
        .br_mispredict_i (br_mispredict_i),
        .entries_o       (entries),
        .ready_o         (ready),
        .free_slots_o    (free_slots_o),
        .rs_full_o       (rs_full_o)
    );

    issue_selector u_issue_sel (
        .entries_i      (entries),
        .ready_i        (ready),
        .fu_busy_i      (fu_busy_i),
        .issue_enable_o (issue_enable),
        .issue_o        (issue_o)
    );

endmodule

/* reservation_station.sv */
// entry array with dispatch routing, branch speculation tracking and free-slot report
`timescale 1ns/1ps
`include "rs_defines.svh"

module reservation_station (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        flush_i,
    // dispatch
    input  logic                 [`DISPATCH_WIDTH-1:0]  disp_valid_i,
    input  rs_pkg::disp_packet_t [`DISPATCH_WIDTH-1:0]  disp_packets_i,
    // bus
    input  core_types_pkg::cdb_t [`CDB_WIDTH-1:0]       cdb_i,
    // from the issue selector
    input  logic                 [`RS_DEPTH-1:0]        issue_enable_i,
    // branch outcome pulses
    input  logic                                        br_resolve_i,
    input  logic                                        br_mispredict_i,
    output rs_pkg::rs_entry_t    [`RS_DEPTH-1:0]        entries_o,
    output logic                 [`RS_DEPTH-1:0]        ready_o,
    output logic [$clog2(`DISPATCH_WIDTH+1)-1:0]        free_slots_o,
    output logic                                        rs_full_o
);

    logic [`RS_DEPTH-1:0] empty;
    // one-hot entry per slot
    logic [`DISPATCH_WIDTH-1:0][`RS_DEPTH-1:0] grant;

    // per-entry dispatch inputs
    logic                 [`RS_DEPTH-1:0] disp_enable;
    rs_pkg::disp_packet_t [`RS_DEPTH-1:0] disp_packet;
    logic                 [`RS_DEPTH-1:0] disp_spec;

    // per-slot view
    logic [`DISPATCH_WIDTH-1:0] slot_go;
    logic [`DISPATCH_WIDTH-1:0] slot_spec;

    // unresolved branch in flight
    logic br_pending_q;
    logic br_pending_d;
    logic br_resolved;

    // ==============================
    // branch tracker
    // ==============================
    // mispredict counts as a resolution too
    assign br_resolved = br_resolve_i || br_mispredict_i;

    always_comb begin
        // resolution this cycle closes the old window before slot 0
        br_pending_d = br_pending_q && !br_resolved;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            // nothing enters on a mispredict
            slot_go[s]   = disp_valid_i[s] && (|grant[s]) && !br_mispredict_i;
            slot_spec[s] = br_pending_d;
            // later slots sit behind this branch
            if (slot_go[s] && (disp_packets_i[s].fu_type == core_types_pkg::FU_BRANCH)) begin
                br_pending_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            br_pending_q <= 1'b0;
        end else begin
            br_pending_q <= br_pending_d;
        end
    end

    // ==============================
    // dispatch routing
    // ==============================
    dispatch_selector u_disp_sel (
        .empty_i      (empty),
        .disp_valid_i (disp_valid_i),
        .grant_o      (grant)
    );

    always_comb begin
        disp_enable = '0;
        disp_packet = '0;
        disp_spec   = '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (slot_go[s] && grant[s][e]) begin
                    disp_enable[e] = 1'b1;
                    disp_packet[e] = disp_packets_i[s];
                    disp_spec[e]   = slot_spec[s];
                end
            end
        end
    end

    // ==============================
    // entry array
    // ==============================
    for (genvar e = 0; e < `RS_DEPTH; e++) begin : g_entry
        rs_entry u_entry (
            .clock         (clock),
            .reset         (reset),
            .flush_i       (flush_i),
            .disp_enable_i (disp_enable[e]),
            .disp_packet_i (disp_packet[e]),
            .spec_i        (disp_spec[e]),
            .issue_i       (issue_enable_i[e]),
            .cdb_i         (cdb_i),
            .clear_spec_i  (br_resolve_i),
            .squash_spec_i (br_mispredict_i),
            .entry_o       (entries_o[e]),
            .empty_o       (empty[e]),
            .ready_o       (ready_o[e])
        );
    end

    // ==============================
    // free slots
    // ==============================
    // saturates at the dispatch width
    always_comb begin
        free_slots_o = '0;
        for (int e = 0; e < `RS_DEPTH; e++) begin
            if (empty[e] && (free_slots_o < `DISPATCH_WIDTH)) begin
                free_slots_o = free_slots_o + 1'b1;
            end
        end
    end

    assign rs_full_o = ~|empty;

    // dispatch stage must respect the advertised count
    a_disp_within_free: assert property (@(posedge clock) disable iff (reset)
        $countones(disp_valid_i) <= free_slots_o);

endmodule

/* issue_selector.sv */
// per unit type, picks the lowest ready entry of that type when the unit can take it
`timescale 1ns/1ps
`include "rs_defines.svh"

module issue_selector (
    input  rs_pkg::rs_entry_t     [`RS_DEPTH-1:0] entries_i,
    input  logic                  [`RS_DEPTH-1:0] ready_i,
    input  logic                  [`FU_NUM-1:0]   fu_busy_i,
    output logic                  [`RS_DEPTH-1:0] issue_enable_o,
    output rs_pkg::issue_packet_t [`FU_NUM-1:0]   issue_o
);

    // chosen entry per port
    rs_pkg::rs_idx_t [`FU_NUM-1:0] pick;
    logic            [`FU_NUM-1:0] found;

    // ==============================
    // pick
    // ==============================
    always_comb begin
        found = '0;
        pick  = '0;
        for (int f = 0; f < `FU_NUM; f++) begin
            // scanning downward leaves the lowest match
            for (int e = `RS_DEPTH - 1; e >= 0; e--) begin
                if (ready_i[e] && !fu_busy_i[f] &&
                    (entries_i[e].packet.fu_type == core_types_pkg::fu_type_e'(f))) begin
                    found[f] = 1'b1;
                    pick[f]  = rs_pkg::rs_idx_t'(e);
                end
            end
        end
    end

    // ==============================
    // grant back and pack
    // ==============================
    always_comb begin
        issue_enable_o = '0;
        for (int f = 0; f < `FU_NUM; f++) begin
            if (found[f]) begin
                issue_enable_o[pick[f]] = 1'b1;
            end
            issue_o[f].valid    = found[f];
            issue_o[f].op       = entries_i[pick[f]].packet.op;
            issue_o[f].dest_tag = entries_i[pick[f]].packet.dest_tag;
            issue_o[f].src1_tag = entries_i[pick[f]].packet.src1_tag;
            issue_o[f].src2_tag = entries_i[pick[f]].packet.src2_tag;
            issue_o[f].rob_idx  = entries_i[pick[f]].packet.rob_idx;
        end
    end

    // one entry per port, no entry on two ports
    always_comb begin
        a_one_grant_per_type: assert final ($countones(issue_enable_o) == $countones(found))
            else $error("issue grant shared between unit types");
    end

endmodule

/* dispatch_selector.sv */
// gives each valid dispatch slot its own free entry, lowest index first
`timescale 1ns/1ps
`include "rs_defines.svh"

module dispatch_selector (
    input  logic [`RS_DEPTH-1:0]                       empty_i,
    input  logic [`DISPATCH_WIDTH-1:0]                 disp_valid_i,
    output logic [`DISPATCH_WIDTH-1:0][`RS_DEPTH-1:0]  grant_o
);

    // entries still open to later slots
    logic [`RS_DEPTH-1:0] avail;
    logic                 taken;
    // union of grants so far
    logic [`RS_DEPTH-1:0] seen;
    logic                 overlap;

    always_comb begin
        avail   = empty_i;
        grant_o = '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            taken = 1'b0;
            // first open entry wins
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (disp_valid_i[s] && !taken && avail[e]) begin
                    grant_o[s][e] = 1'b1;
                    avail[e]      = 1'b0;
                    taken         = 1'b1;
                end
            end
        end
    end

    // two slots landing in one entry would drop an instruction
    always_comb begin
        seen    = '0;
        overlap = 1'b0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            overlap = overlap || (|(seen & grant_o[s])) || !$onehot0(grant_o[s]);
            seen    = seen | grant_o[s];
        end
    end

    always_comb begin
        a_no_overlap: assert final (!overlap)
            else $error("dispatch grants overlap");
    end

endmodule

/* rs_entry.sv */
// one station slot, holds a renamed instruction, watches the bus and reports when it can issue
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_entry (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   flush_i,
    // dispatch side
    input  logic                                   disp_enable_i,
    input  rs_pkg::disp_packet_t                   disp_packet_i,
    input  logic                                   spec_i,
    // picked by the issue selector
    input  logic                                   issue_i,
    // result broadcast
    input  core_types_pkg::cdb_t [`CDB_WIDTH-1:0]  cdb_i,
    // branch outcome
    input  logic                                   clear_spec_i,
    input  logic                                   squash_spec_i,
    output rs_pkg::rs_entry_t                      entry_o,
    output logic                                   empty_o,
    output logic                                   ready_o
);

    // control state
    logic valid_q;
    logic spec_q;
    // payload
    rs_pkg::disp_packet_t pkt_q;

    // packet under wakeup, the incoming one while dispatching
    rs_pkg::disp_packet_t pkt_watch;
    logic src1_hit;
    logic src2_hit;
    // slot leaves this cycle
    logic kill;

    // ==============================
    // wakeup compare
    // ==============================
    always_comb begin
        pkt_watch = disp_enable_i ? disp_packet_i : pkt_q;
        src1_hit  = 1'b0;
        src2_hit  = 1'b0;
        // every lane against both sources
        for (int l = 0; l < `CDB_WIDTH; l++) begin
            if (cdb_i[l].valid && (cdb_i[l].tag == pkt_watch.src1_tag)) begin
                src1_hit = 1'b1;
            end
            if (cdb_i[l].valid && (cdb_i[l].tag == pkt_watch.src2_tag)) begin
                src2_hit = 1'b1;
            end
        end
    end

    // issued, or caught by a mispredict while speculative
    assign kill = issue_i || (squash_spec_i && spec_q);

    // ==============================
    // occupancy and speculation
    // ==============================
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            valid_q <= 1'b0;
            spec_q  <= 1'b0;
        end else if (disp_enable_i) begin
            valid_q <= 1'b1;
            spec_q  <= spec_i;
        end else if (kill) begin
            valid_q <= 1'b0;
            spec_q  <= 1'b0;
        end else if (clear_spec_i) begin
            // branch went the predicted way
            spec_q  <= 1'b0;
        end
    end

    // payload, ready bits only ever set
    always_ff @(posedge clock) begin
        if (disp_enable_i) begin
            pkt_q <= disp_packet_i;
        end
        pkt_q.src1_ready <= pkt_watch.src1_ready | src1_hit;
        pkt_q.src2_ready <= pkt_watch.src2_ready | src2_hit;
    end

    assign entry_o = '{valid: valid_q, spec: spec_q, packet: pkt_q};
    assign empty_o = !valid_q;
    assign ready_o = valid_q && pkt_q.src1_ready && pkt_q.src2_ready;

    // dispatch selector only grants slots it saw empty
    a_disp_into_empty: assert property (@(posedge clock) disable iff (reset)
        disp_enable_i |-> !valid_q);

    // issue selector only picks slots with both sources in
    a_issue_when_ready: assert property (@(posedge clock) disable iff (reset)
        issue_i |-> ready_o);

endmodule

/* rs_pkg.sv */
// reservation station types for dispatch, storage and issue, referenced by scoped name
`include "rs_defines.svh"

package rs_pkg;

    // entry index inside the station
    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

    // renamed instruction as it leaves dispatch
    typedef struct packed {
        core_types_pkg::fu_type_e  fu_type;
        core_types_pkg::op_code_t  op;
        core_types_pkg::phys_tag_t dest_tag;
        core_types_pkg::phys_tag_t src1_tag;
        logic                      src1_ready;
        core_types_pkg::phys_tag_t src2_tag;
        logic                      src2_ready;
        core_types_pkg::rob_idx_t  rob_idx;
    } disp_packet_t;

    // one occupied slot
    typedef struct packed {
        logic         valid;
        // younger than an unresolved branch
        logic         spec;
        disp_packet_t packet;
    } rs_entry_t;

    // what a unit receives
    typedef struct packed {
        logic                      valid;
        core_types_pkg::op_code_t  op;
        core_types_pkg::phys_tag_t dest_tag;
        core_types_pkg::phys_tag_t src1_tag;
        core_types_pkg::phys_tag_t src2_tag;
        core_types_pkg::rob_idx_t  rob_idx;
    } issue_packet_t;

endpackage

/* core_types_pkg.sv */
// processor-wide types shared by rename, issue and writeback, referenced by scoped name
`include "rs_defines.svh"

package core_types_pkg;

    // physical register tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;

    // reorder buffer slot
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // unit class, doubles as the issue port index
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_LOAD   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    // operation within a unit
    typedef logic [3:0] op_code_t;

    // one bus lane, a result tag being broadcast
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } cdb_t;

endpackage

/* rs_defines.svh */
// sizing macros for the reservation station and its issue pick, included wherever widths are built
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// station geometry
`define RS_DEPTH 8
// renamed instructions accepted per cycle
`define DISPATCH_WIDTH 2
// common data bus lanes
`define CDB_WIDTH 2

// machine-wide sizes
`define PHYS_REGS 64
`define ROB_DEPTH 32
// alu, mult, load, branch
`define FU_NUM 4

`endif
